// File: bench/bridge_patterns.txt
// op id addr len seed expect, all hex; len is beats minus one
// op 1 write, 2 read, 3 source load, 4 mode (seed bit0 random, bit1 hold full)
1 a001 00 3 1000 0   // 4 beats out, OKAY
1 a002 08 1 2000 2   // bad address
3 0    00 5 3000 0   // source sends 6 words
2 b001 10 0 0    1   // status, not empty
2 b002 00 3 0    0   // read 4
2 b003 10 0 0    1
2 b004 00 1 0    0   // read last 2
2 b005 10 0 0    0   // status, empty
2 b006 00 0 0    2   // underflow
2 b007 20 2 0    2   // bad address
3 0    00 3 4000 0
1 c001 10 0 2    0   // flush inbound
2 c002 10 0 0    0
4 0    00 0 2    0   // hold core full
1 c003 00 5 5000 0   // held back
1 c004 10 0 1    0   // flush outbound
4 0    00 0 1    0   // random back-pressure
1 d001 00 f 6000 0
1 d002 04 2 7000 2
3 0    00 9 8000 0
2 d003 10 0 0    1
2 d004 00 9 0    0
2 d005 10 0 0    0
2 d006 00 0 0    2
1 d007 00 7 9000 0

// File: vlog.f
src/axi_fifo_pkg.sv
src/sync_fifo.sv
src/axi_write_ctrl.sv
src/axi_read_ctrl.sv
src/axi_fifo_bridge.sv
bench/axi_fifo_bridge_chk.sv
bench/tb_axi_fifo_bridge.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_axi_fifo_bridge
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TB PASSED'

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_axi_fifo_bridge.sv
`timescale 1ns/1ps

module tb_axi_fifo_bridge;

    import axi_fifo_pkg::*;

    localparam int PAT_MAX  = 64;
    localparam int PAT_COLS = 6;      // op id addr len seed expect

    logic      s_axi_aclk;
    logic      s_axi_aresetn;
    logic      awvalid;
    axi_req_t  aw;
    logic      awready;
    logic      wvalid;
    axi_word_u wdata;
    logic      wlast;
    logic      wready;
    logic      bvalid;
    axi_b_t    b;
    logic      bready;
    logic      arvalid;
    axi_req_t  ar;
    logic      arready;
    logic      rvalid;
    axi_r_t    r;
    logic      rready;
    logic      core_out_write;
    axi_word_u core_out_data;
    logic      core_out_full = 1'b0;
    logic      core_out_flush;
    axi_word_u core_in_data  = '0;
    logic      core_in_empty = 1'b1;
    logic      core_in_rd_en;
    logic      core_in_flush;

    logic [31:0] pat [PAT_MAX*PAT_COLS];
    int          n_pat         = 0;
    logic        pat_loaded    = 1'b0;
    logic [31:0] lfsr          = 32'h5ae1_2cd2;
    logic        rand_en       = 1'b0;    // Random bready, rready, core_out_full
    logic        hold_full     = 1'b0;    // Core output pinned full
    int          checks        = 0;
    int          errors        = 0;
    int          out_flush_cnt = 0;
    int          in_flush_cnt  = 0;
    axi_word_u   src_q [$];               // Inbound core contents
    axi_word_u   exp_in_q [$];            // Words due on R, in order
    axi_word_u   exp_out_q [$];           // Words due at the outbound core

    axi_fifo_bridge u_dut (.*);

    initial begin
        s_axi_aclk = 1'b0;
        forever #2 s_axi_aclk = ~s_axi_aclk;
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////
    function automatic axi_word_u make_word(input logic [31:0] seed, input int idx);
        axi_word_u   w;
        logic [31:0] s;
        s     = seed + 32'(idx);
        w.raw = {s, ~s, s ^ 32'h9e37_79b9, seed[15:0], 16'(idx)};
        return w;
    endfunction

    // Galois LFSR, one step per bit
    function automatic logic take_bit();
        logic out_bit;
        out_bit = lfsr[0];
        lfsr    = lfsr >> 1;
        if (out_bit) begin
            lfsr = lfsr ^ 32'h8020_0003;
        end
        return out_bit;
    endfunction

    task automatic check_b(input axi_b_t got, input axi_b_t exp_b);
        checks++;
        if (got !== exp_b) begin
            errors++;
            $display("Fail %0t: B id %h resp %0d, expected id %h resp %0d",
                     $time, got.id, got.resp, exp_b.id, exp_b.resp);
        end
    endtask

    task automatic check_r(input axi_r_t got, input axi_r_t exp_r);
        checks++;
        if (got !== exp_r) begin
            errors++;
            $display("Fail %0t: R id %h data %h resp %0d last %b", $time,
                     got.id, got.data.raw, got.resp, got.last);
            $display("    expected id %h data %h resp %0d last %b",
                     exp_r.id, exp_r.data.raw, exp_r.resp, exp_r.last);
        end
    endtask

    task automatic check_word(input axi_word_u got, input axi_word_u exp_w, input string what);
        checks++;
        if (got !== exp_w) begin
            errors++;
            $display("Fail %0t: %s got %h, expected %h", $time, what, got.raw, exp_w.raw);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // AXI master
    //////////////////////////////////////////////////////////////////////
    task automatic write_burst(input logic [31:0] id, input logic [31:0] addr,
                               input logic [31:0] len, input logic [31:0] seed,
                               input logic cmd, output axi_b_t got);
        axi_req_t  req;
        axi_word_u w;
        req.id   = id[ID_W-1:0];
        req.addr = addr[ADDR_W-1:0];
        req.len  = len[LEN_W-1:0];
        @(posedge s_axi_aclk);
        awvalid <= 1'b1;
        aw      <= req;
        @(posedge s_axi_aclk);
        while (!awready) @(posedge s_axi_aclk);
        awvalid <= 1'b0;
        for (int k = 0; k <= int'(len); k++) begin
            w = make_word(seed, k);
            if (cmd) begin
                w.raw = DATA_W'(seed);                 // Command bits as given
            end
            wvalid <= 1'b1;
            wdata  <= w;
            wlast  <= (k == int'(len));
            @(posedge s_axi_aclk);
            while (!wready) @(posedge s_axi_aclk);   // Stalls on a full FIFO
        end
        wvalid <= 1'b0;
        wlast  <= 1'b0;
        bready <= rand_en ? take_bit() : 1'b1;
        @(posedge s_axi_aclk);
        while (!(bvalid && bready)) begin
            bready <= rand_en ? take_bit() : 1'b1;
            @(posedge s_axi_aclk);
        end
        got = b;
        bready <= 1'b0;
    endtask

    task automatic read_burst(input logic [31:0] id, input logic [31:0] addr,
                              input logic [31:0] len, input logic [31:0] expv);
        axi_req_t req;
        axi_r_t   got;
        axi_r_t   exp_r;
        int       beats;
        logic     done;
        req.id   = id[ID_W-1:0];
        req.addr = addr[ADDR_W-1:0];
        req.len  = len[LEN_W-1:0];
        beats    = (req.addr == ADDR_FIFO) ? int'(len) + 1 : 1;   // Else one beat
        done     = 1'b0;
        @(posedge s_axi_aclk);
        arvalid <= 1'b1;
        ar      <= req;
        @(posedge s_axi_aclk);
        while (!arready) @(posedge s_axi_aclk);
        arvalid <= 1'b0;
        rready  <= rand_en ? take_bit() : 1'b1;
        for (int k = 0; k < beats && !done; k++) begin
            @(posedge s_axi_aclk);
            while (!(rvalid && rready)) begin
                rready <= rand_en ? take_bit() : 1'b1;
                @(posedge s_axi_aclk);
            end
            got    = r;
            rready <= rand_en ? take_bit() : 1'b1;
            exp_r      = '0;
            exp_r.id   = req.id;
            exp_r.last = (k == beats - 1);
            if (req.addr == ADDR_CTRL) begin
                exp_r.data.ctrl.flush_out = expv[0];   // Not-empty status
            end else begin
                exp_r.resp = expv[1:0];
                if (req.addr == ADDR_FIFO && expv[1:0] == RESP_OKAY) begin
                    if (exp_in_q.size() == 0) begin
                        errors++;
                        $display("Read at %0t expects a word the source never sent", $time);
                    end else begin
                        exp_r.data = exp_in_q.pop_front();
                    end
                end
            end
            check_r(got, exp_r);
            done = got.last;
        end
        rready <= 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Core models
    //////////////////////////////////////////////////////////////////////
    always @(posedge s_axi_aclk) begin
        if (s_axi_aresetn && core_out_write) begin
            if (exp_out_q.size() == 0) begin
                errors++;
                $display("Unexpected word %h reached the core output at %0t",
                         core_out_data.raw, $time);
            end else begin
                check_word(core_out_data, exp_out_q.pop_front(), "core output");
            end
        end
    end

    // Inbound source, head word shown while not empty
    always @(posedge s_axi_aclk) begin
        if (core_in_rd_en && src_q.size() > 0) begin
            void'(src_q.pop_front());
        end
        core_in_empty <= (src_q.size() == 0);
        if (src_q.size() > 0) begin
            core_in_data <= src_q[0];
        end
    end

    always @(posedge s_axi_aclk) begin
        core_out_full <= hold_full || (rand_en && take_bit());
    end

    always @(posedge s_axi_aclk) begin
        if (core_out_flush) out_flush_cnt <= out_flush_cnt + 1;
        if (core_in_flush)  in_flush_cnt  <= in_flush_cnt + 1;
    end

    // Run limit scales with the pattern count
    initial begin
        wait (pat_loaded);
        repeat ((n_pat + 1) * 200) @(posedge s_axi_aclk);
        $display("Watchdog expired after %0d cycles, the run is stuck", (n_pat + 1) * 200);
        $display("TB FAILED");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////
    initial begin
        logic [31:0] op;
        logic [31:0] id;
        logic [31:0] addr;
        logic [31:0] len;
        logic [31:0] seed;
        logic [31:0] expv;
        axi_b_t      got_b;
        axi_b_t      exp_b;
        axi_word_u   got_w;
        axi_word_u   exp_w;
        int          o0;
        int          i0;
        s_axi_aresetn = 1'b0;
        awvalid       = 1'b0;
        aw            = '0;
        wvalid        = 1'b0;
        wdata         = '0;
        wlast         = 1'b0;
        bready        = 1'b0;
        arvalid       = 1'b0;
        ar            = '0;
        rready        = 1'b0;
        for (int i = 0; i < PAT_MAX * PAT_COLS; i++) begin
            pat[i] = '1;                               // Unused rows stay all ones
        end
        $readmemh("bench/bridge_patterns.txt", pat);
        while (n_pat < PAT_MAX && pat[n_pat * PAT_COLS] != '1) n_pat++;
        if (n_pat == 0) begin
            errors++;
            $display("No patterns were read from the pattern file");
        end
        pat_loaded = 1'b1;
        repeat (16) @(posedge s_axi_aclk);
        s_axi_aresetn <= 1'b1;

        for (int p = 0; p < n_pat; p++) begin
            op   = pat[p * PAT_COLS];
            id   = pat[p * PAT_COLS + 1];
            addr = pat[p * PAT_COLS + 2];
            len  = pat[p * PAT_COLS + 3];
            seed = pat[p * PAT_COLS + 4];
            expv = pat[p * PAT_COLS + 5];
            case (op)
                1: begin                               // AXI write
                    if (addr[ADDR_W-1:0] == ADDR_FIFO && !hold_full) begin
                        for (int k = 0; k <= int'(len); k++) begin
                            exp_out_q.push_back(make_word(seed, k));
                        end
                    end
                    o0 = out_flush_cnt;
                    i0 = in_flush_cnt;
                    write_burst(id, addr, len, seed, addr[ADDR_W-1:0] == ADDR_CTRL, got_b);
                    exp_b.id   = id[ID_W-1:0];
                    exp_b.resp = expv[1:0];
                    check_b(got_b, exp_b);
                    if (addr[ADDR_W-1:0] == ADDR_CTRL) begin
                        repeat (2) @(posedge s_axi_aclk);
                        got_w                = '0;
                        got_w.ctrl.flush_out = (out_flush_cnt != o0);
                        got_w.ctrl.flush_in  = (in_flush_cnt != i0);
                        exp_w                = '0;
                        exp_w.ctrl.flush_out = seed[0];
                        exp_w.ctrl.flush_in  = seed[1];
                        check_word(got_w, exp_w, "flush strobes");
                        if (seed[1]) begin
                            exp_in_q.delete();         // Inbound words dropped
                        end
                    end
                end
                2: read_burst(id, addr, len, expv);
                3: begin                               // Source delivers len+1 words
                    for (int k = 0; k <= int'(len); k++) begin
                        src_q.push_back(make_word(seed, k));
                        exp_in_q.push_back(make_word(seed, k));
                    end
                    while (src_q.size() != 0) @(posedge s_axi_aclk);
                end
                4: begin
                    rand_en   <= seed[0];
                    hold_full <= seed[1];
                    @(posedge s_axi_aclk);
                end
                default: begin
                    errors++;
                    $display("Pattern %0d has an unknown operation code %0h", p, op);
                end
            endcase
        end

        // Drain the outbound path
        rand_en   <= 1'b0;
        hold_full <= 1'b0;
        for (int c = 0; c < 100 && exp_out_q.size() != 0; c++) @(posedge s_axi_aclk);
        if (exp_out_q.size() != 0) begin
            errors++;
            $display("%0d words never reached the core output", exp_out_q.size());
        end
        if (exp_in_q.size() != 0) begin
            errors++;
            $display("%0d inbound words were never read back", exp_in_q.size());
        end
        repeat (4) @(posedge s_axi_aclk);
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: bench/axi_fifo_bridge_chk.sv
`timescale 1ns/1ps

module axi_fifo_bridge_chk (
    input logic                 s_axi_aclk,
    input logic                 s_axi_aresetn,
    input logic                 awvalid,
    input logic                 awready,
    input logic                 bvalid,
    input logic                 bready,
    input axi_fifo_pkg::axi_b_t b,
    input logic                 rvalid,
    input logic                 rready,
    input axi_fifo_pkg::axi_r_t r,
    input logic                 out_push,       // Outbound FIFO push, inside the bridge
    input logic                 core_out_write,
    input logic                 core_out_full
);

    //////////////////////////////////////////////////////////////////////
    // Handshake rules
    //////////////////////////////////////////////////////////////////////
    b_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        bvalid && !bready |=> bvalid && $stable(b))
        else $error("B response changed before bready");

    r_hold: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        rvalid && !rready |=> rvalid && $stable(r))
        else $error("R beat changed before rready");

    // Pushed word offered to the core one cycle later unless it is full
    out_drain: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        out_push |=> core_out_write || core_out_full)
        else $error("Pushed word was not offered to the outbound core");

    // Low from the AW transfer until the B transfer
    aw_blocked: assert property (@(posedge s_axi_aclk) disable iff (!s_axi_aresetn)
        (awvalid || !awready) && !(bvalid && bready) |=> !awready)
        else $error("awready rose before the B transfer");

endmodule

bind axi_fifo_bridge axi_fifo_bridge_chk u_chk (
    .s_axi_aclk     (s_axi_aclk),
    .s_axi_aresetn  (s_axi_aresetn),
    .awvalid        (awvalid),
    .awready        (awready),
    .bvalid         (bvalid),
    .bready         (bready),
    .b              (b),
    .rvalid         (rvalid),
    .rready         (rready),
    .r              (r),
    .out_push       (out_push),
    .core_out_write (core_out_write),
    .core_out_full  (core_out_full)
);

// File: src/axi_fifo_bridge.sv
`timescale 1ns/1ps

module axi_fifo_bridge (
    input  logic                    s_axi_aclk,
    input  logic                    s_axi_aresetn,
    // AXI write
    input  logic                    awvalid,
    input  axi_fifo_pkg::axi_req_t  aw,
    output logic                    awready,
    input  logic                    wvalid,
    input  axi_fifo_pkg::axi_word_u wdata,
    input  logic                    wlast,
    output logic                    wready,
    output logic                    bvalid,
    output axi_fifo_pkg::axi_b_t    b,
    input  logic                    bready,
    // AXI read
    input  logic                    arvalid,
    input  axi_fifo_pkg::axi_req_t  ar,
    output logic                    arready,
    output logic                    rvalid,
    output axi_fifo_pkg::axi_r_t    r,
    input  logic                    rready,
    // Outbound core
    output logic                    core_out_write,
    output axi_fifo_pkg::axi_word_u core_out_data,
    input  logic                    core_out_full,
    output logic                    core_out_flush,
    // Inbound core
    input  axi_fifo_pkg::axi_word_u core_in_data,
    input  logic                    core_in_empty,
    output logic                    core_in_rd_en,
    output logic                    core_in_flush
);

    import axi_fifo_pkg::*;

    logic      out_push;
    axi_word_u out_push_data;
    logic      out_empty;
    logic      out_full;
    logic      in_pop;
    axi_word_u in_head;
    logic      in_empty;
    logic      in_full;

    //////////////////////////////////////////////////////////////////////
    // Core side flow control
    //////////////////////////////////////////////////////////////////////
    assign core_out_write = !out_empty && !core_out_full;   // Drain when core has room
    assign core_in_rd_en  = !core_in_empty && !in_full;     // Fill while space left

    axi_write_ctrl u_write_ctrl (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .awvalid       (awvalid),
        .aw            (aw),
        .awready       (awready),
        .wvalid        (wvalid),
        .wdata         (wdata),
        .wlast         (wlast),
        .wready        (wready),
        .bvalid        (bvalid),
        .b             (b),
        .bready        (bready),
        .fifo_full     (out_full),
        .fifo_push     (out_push),
        .fifo_data     (out_push_data),
        .flush_out     (core_out_flush),
        .flush_in      (core_in_flush)
    );

    axi_read_ctrl u_read_ctrl (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .arvalid       (arvalid),
        .ar            (ar),
        .arready       (arready),
        .rvalid        (rvalid),
        .r             (r),
        .rready        (rready),
        .fifo_head     (in_head),
        .fifo_empty    (in_empty),
        .fifo_pop      (in_pop)
    );

    // AXI to core
    sync_fifo u_out_fifo (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .clear         (core_out_flush),    // Local copy flushed with the core
        .push          (out_push),
        .push_data     (out_push_data),
        .pop           (core_out_write),
        .head          (core_out_data),
        .empty         (out_empty),
        .full          (out_full)
    );

    // Core to AXI
    sync_fifo u_in_fifo (
        .s_axi_aclk    (s_axi_aclk),
        .s_axi_aresetn (s_axi_aresetn),
        .clear         (core_in_flush),
        .push          (core_in_rd_en),
        .push_data     (core_in_data),
        .pop           (in_pop),
        .head          (in_head),
        .empty         (in_empty),
        .full          (in_full)
    );

endmodule

// File: src/axi_read_ctrl.sv
`timescale 1ns/1ps

module axi_read_ctrl (
    input  logic                    s_axi_aclk,
    input  logic                    s_axi_aresetn,
    // AR
    input  logic                    arvalid,
    input  axi_fifo_pkg::axi_req_t  ar,
    output logic                    arready,
    // R
    output logic                    rvalid,
    output axi_fifo_pkg::axi_r_t    r,
    input  logic                    rready,
    // Inbound FIFO
    input  axi_fifo_pkg::axi_word_u fifo_head,
    input  logic                    fifo_empty,
    output logic                    fifo_pop
);

    import axi_fifo_pkg::*;

    typedef enum logic {
        R_IDLE,
        R_BURST     // A beat sits on R
    } rd_state_t;

    rd_state_t        state;
    logic [LEN_W-1:0] beats_left;      // Beats after the one on R
    logic             ar_fire;
    logic             r_fire;
    logic             next_beat;       // Load a FIFO beat on this edge
    axi_word_u        head_word;
    logic [1:0]       head_resp;
    axi_word_u        stat_word;

    assign arready = (state == R_IDLE);
    assign rvalid  = (state == R_BURST);
    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    // First FIFO beat at AR, later ones as each beat is taken
    assign next_beat = (ar_fire && (ar.addr == ADDR_FIFO))
                    || (r_fire && !r.last);
    assign fifo_pop  = next_beat && !fifo_empty;   // Word is captured as it leaves

    //////////////////////////////////////////////////////////////////////
    // Beat contents
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        head_word     = fifo_head;
        head_resp     = RESP_OKAY;
        if (fifo_empty) begin
            head_word.raw = '0;                    // Underflow beat
            head_resp     = RESP_SLVERR;
        end
        stat_word                = '0;
        stat_word.ctrl.flush_out = !fifo_empty;    // Status bit 0
    end

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state      <= R_IDLE;
            beats_left <= '0;
        end else if (ar_fire) begin
            state      <= R_BURST;
            beats_left <= ar.len;
        end else if (r_fire) begin
            if (r.last) begin
                state <= R_IDLE;                   // arready back up
            end else begin
                beats_left <= beats_left - 1'b1;
            end
        end
    end

    // R payload, only changes on AR or on a taken beat
    always_ff @(posedge s_axi_aclk) begin
        if (ar_fire) begin
            r.id <= ar.id;
            case (ar.addr)
                ADDR_FIFO: begin
                    r.data <= head_word;
                    r.resp <= head_resp;
                    r.last <= (ar.len == '0);
                end
                ADDR_CTRL: begin
                    r.data <= stat_word;
                    r.resp <= RESP_OKAY;
                    r.last <= 1'b1;
                end
                default: begin
                    r.data <= '0;
                    r.resp <= RESP_SLVERR;
                    r.last <= 1'b1;                // Single error beat
                end
            endcase
        end else if (r_fire && next_beat) begin
            r.data <= head_word;
            r.resp <= head_resp;
            r.last <= (beats_left == LEN_W'(1));
        end
    end

endmodule

// File: src/axi_write_ctrl.sv
`timescale 1ns/1ps

module axi_write_ctrl (
    input  logic                    s_axi_aclk,
    input  logic                    s_axi_aresetn,
    // AW
    input  logic                    awvalid,
    input  axi_fifo_pkg::axi_req_t  aw,
    output logic                    awready,
    // W
    input  logic                    wvalid,
    input  axi_fifo_pkg::axi_word_u wdata,
    input  logic                    wlast,
    output logic                    wready,
    // B
    output logic                    bvalid,
    output axi_fifo_pkg::axi_b_t    b,
    input  logic                    bready,
    // Outbound FIFO
    input  logic                    fifo_full,
    output logic                    fifo_push,
    output axi_fifo_pkg::axi_word_u fifo_data,
    // Flush strobes, one cycle each
    output logic                    flush_out,
    output logic                    flush_in
);

    import axi_fifo_pkg::*;

    typedef enum logic [1:0] {
        W_IDLE,
        W_DATA,     // Beats go to the outbound FIFO
        W_CMD,      // Beats decoded as flush commands
        W_DISC      // Bad address, beats dropped
    } wr_state_t;

    wr_state_t state;
    logic      aw_fire;
    logic      w_fire;

    //////////////////////////////////////////////////////////////////////
    // Handshakes
    //////////////////////////////////////////////////////////////////////
    assign awready = (state == W_IDLE) && !bvalid;     // Held off until B done
    assign wready  = ((state == W_DATA) && !fifo_full)
                  || (state == W_CMD)
                  || (state == W_DISC);
    assign aw_fire = awvalid && awready;
    assign w_fire  = wvalid && wready;

    // Beat lands in the FIFO on this edge
    assign fifo_push = (state == W_DATA) && w_fire;
    assign fifo_data = wdata;

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn) begin
            state     <= W_IDLE;
            bvalid    <= 1'b0;
            flush_out <= 1'b0;
            flush_in  <= 1'b0;
        end else begin
            flush_out <= 1'b0;                         // Pulses by default
            flush_in  <= 1'b0;
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            case (state)
                W_IDLE: begin
                    if (aw_fire) begin
                        case (aw.addr)
                            ADDR_FIFO: state <= W_DATA;
                            ADDR_CTRL: state <= W_CMD;
                            default:   state <= W_DISC;
                        endcase
                    end
                end
                W_CMD: begin
                    if (w_fire) begin
                        // Command view of the same word
                        flush_out <= wdata.ctrl.flush_out;
                        flush_in  <= wdata.ctrl.flush_in;
                    end
                    if (w_fire && wlast) begin
                        state  <= W_IDLE;
                        bvalid <= 1'b1;
                    end
                end
                default: begin                         // W_DATA, W_DISC
                    if (w_fire && wlast) begin
                        state  <= W_IDLE;
                        bvalid <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Response payload, stable while bvalid since no AW can fire
    always_ff @(posedge s_axi_aclk) begin
        if (aw_fire) begin
            b.id <= aw.id;
        end
        if (w_fire && wlast) begin
            b.resp <= (state == W_DISC) ? RESP_SLVERR : RESP_OKAY;
        end
    end

endmodule

// File: src/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo (
    input  logic                   s_axi_aclk,
    input  logic                   s_axi_aresetn,
    input  logic                   clear,       // Drops all entries
    input  logic                   push,
    input  axi_fifo_pkg::axi_word_u push_data,
    input  logic                   pop,
    output axi_fifo_pkg::axi_word_u head,       // First word, valid while not empty
    output logic                   empty,
    output logic                   full
);

    import axi_fifo_pkg::*;

    axi_word_u            mem [1 << FIFO_AW];
    logic [FIFO_AW-1:0]   wr_ptr;
    logic [FIFO_AW-1:0]   rd_ptr;
    logic [FIFO_AW:0]     count;    // One extra bit so 32 fits

    // Storage, pointers decide what is live
    always_ff @(posedge s_axi_aclk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (!s_axi_aresetn || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;       // Wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;       // Both or neither
            endcase
        end
    end

    // Fall-through read port
    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = count[FIFO_AW];     // Only set at exactly 32

endmodule

// File: src/axi_fifo_pkg.sv
package axi_fifo_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////
    localparam int ID_W    = 16;
    localparam int ADDR_W  = 6;
    localparam int DATA_W  = 128;
    localparam int LEN_W   = 8;
    localparam int FIFO_AW = 5;        // 32 entries per direction

    // Address map, same for read and write
    localparam logic [ADDR_W-1:0] ADDR_FIFO = 6'h00;
    localparam logic [ADDR_W-1:0] ADDR_CTRL = 6'h10;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    //////////////////////////////////////////////////////////////////////
    // Channel payloads
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;        // Beats minus one
    } axi_req_t;                       // AW and AR

    // Command on write to ADDR_CTRL, status on read from it
    typedef struct packed {
        logic [DATA_W-3:0] rsvd;
        logic              flush_in;   // Inbound flush
        logic              flush_out;  // Outbound flush / inbound not empty
    } ctrl_word_t;

    typedef union packed {
        logic [DATA_W-1:0] raw;        // FIFO payload
        ctrl_word_t        ctrl;
    } axi_word_u;

    typedef struct packed {
        logic [ID_W-1:0] id;
        logic [1:0]      resp;
    } axi_b_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        axi_word_u       data;
        logic [1:0]      resp;
        logic            last;
    } axi_r_t;

endpackage
